/* logic/aes_types_pkg.sv */
package aes_types_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [31:0] col_t;
  typedef logic [3:0] rkey_idx_t;

  // byte 0 and column 0 sit in the top bits
  typedef union packed {
    byte_t [0:15] bytes;
    col_t [0:3] cols;
  } aes_block_u;

  localparam rkey_idx_t NUM_ROUNDS = 4'd10;
  localparam int NUM_ROUND_KEYS = 11;

  // multiply by two in GF(2^8)
  function automatic byte_t xtime(byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

/* logic/aes_map_pkg.sv */
package aes_map_pkg;

  localparam int ADDR_W = 5;

  // rows 0 to 15 of the table while this bit is clear
  localparam int TABLE_SEL_BIT = 4;

  localparam logic [ADDR_W-1:0] ADDR_KEY = 5'd16;
  localparam logic [ADDR_W-1:0] ADDR_TEXT = 5'd17;

  // arbiter requester ids
  localparam logic REQ_KEY = 1'b0;
  localparam logic REQ_CIPHER = 1'b1;

endpackage

/* logic/sbox_lookup_if.sv */
`timescale 1ns/1ps

interface sbox_lookup_if;
  import aes_types_pkg::*;

  logic req;
  logic grant;
  // four table addresses, one per byte lane
  col_t index;
  col_t result;

  modport engine (
    output req,
    output index,
    input  grant,
    input  result
  );

  modport arbiter (
    input  req,
    input  index,
    output grant,
    output result
  );

endinterface

/* logic/sbox_arbiter.sv */
`timescale 1ns/1ps

module sbox_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  sbox_lookup_if.arbiter       key_port,
  sbox_lookup_if.arbiter       cipher_port,
  output aes_types_pkg::col_t  rd_index,
  input  aes_types_pkg::col_t  rd_data
);
  import aes_map_pkg::*;

  logic last_winner;

  // on a tie the engine that lost last time wins
  assign key_port.grant = key_port.req &&
                          (!cipher_port.req || last_winner == REQ_CIPHER);
  assign cipher_port.grant = cipher_port.req &&
                             (!key_port.req || last_winner == REQ_KEY);

  assign rd_index = cipher_port.grant ? cipher_port.index : key_port.index;

  assign key_port.result = rd_data;
  assign cipher_port.result = rd_data;

  always_ff @(posedge clk)
  begin
    if (rst)
      last_winner <= REQ_CIPHER;
    else if (key_port.grant)
      last_winner <= REQ_KEY;
    else if (cipher_port.grant)
      last_winner <= REQ_CIPHER;
  end

  // a refused requester is served on the next cycle
  key_waits_once: assert property (@(posedge clk) disable iff (rst)
    key_port.req && !key_port.grant |=> !key_port.req || key_port.grant);

  cipher_waits_once: assert property (@(posedge clk) disable iff (rst)
    cipher_port.req && !cipher_port.grant |=> !cipher_port.req || cipher_port.grant);

endmodule

/* logic/sbox_table.sv */
`timescale 1ns/1ps

module sbox_table (
  input  logic                            clk,
  input  logic                            load,
  input  logic [aes_map_pkg::ADDR_W-1:0]  address,
  input  aes_types_pkg::aes_block_u       din,
  input  aes_types_pkg::col_t             rd_index,
  output aes_types_pkg::col_t             rd_data
);
  import aes_types_pkg::*;
  import aes_map_pkg::*;

  byte_t mem [0:255];
  logic row_we;

  assign row_we = load && !address[TABLE_SEL_BIT];

  // one host write fills sixteen consecutive entries
  always_ff @(posedge clk)
  begin
    if (row_we)
    begin
      for (int i = 0; i < 16; i++)
      begin
        mem[{address[3:0], 4'(i)}] <= din.bytes[i];
      end
    end
  end

  // four independent read lanes
  assign rd_data = {
    mem[rd_index[31:24]],
    mem[rd_index[23:16]],
    mem[rd_index[15:8]],
    mem[rd_index[7:0]]
  };

  load_addr_known: assert property (@(posedge clk)
    load |-> !$isunknown(address));

endmodule

/* logic/key_expander.sv */
`timescale 1ns/1ps

module key_expander (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       key_start,
  input  aes_types_pkg::aes_block_u  key,
  sbox_lookup_if.engine              lookup,
  input  aes_types_pkg::rkey_idx_t   rk_index,
  output aes_types_pkg::aes_block_u  rk_data,
  output aes_types_pkg::rkey_idx_t   rk_avail,
  output logic                       key_ready
);
  import aes_types_pkg::*;

  logic busy;
  logic start;
  logic step;
  rkey_idx_t rk_count;
  byte_t rcon;
  col_t last_word;
  col_t sub_word;
  aes_block_u rk_cur;
  aes_block_u rk_next;
  aes_block_u rk_file [0:NUM_ROUND_KEYS-1];

  assign start = key_start && !busy;
  assign step = busy && lookup.grant;

  // rot word of the last column
  assign last_word = rk_cur.cols[3];
  assign lookup.req = busy;
  assign lookup.index = {last_word[23:0], last_word[31:24]};

  assign sub_word = lookup.result ^ {rcon, 24'h000000};

  // each word chains off the one before
  always_comb
  begin
    rk_next.cols[0] = sub_word ^ rk_cur.cols[0];
    rk_next.cols[1] = rk_next.cols[0] ^ rk_cur.cols[1];
    rk_next.cols[2] = rk_next.cols[1] ^ rk_cur.cols[2];
    rk_next.cols[3] = rk_next.cols[2] ^ rk_cur.cols[3];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      rk_count <= '0;
      rcon <= 8'h01;
    end
    else if (start)
    begin
      busy <= 1'b1;
      rk_count <= 4'd1;
      rcon <= 8'h01;
    end
    else if (step)
    begin
      rk_count <= rk_count + 4'd1;
      rcon <= xtime(rcon);
      if (rk_count == NUM_ROUNDS)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      rk_cur <= key;
      rk_file[0] <= key;
    end
    else if (step)
    begin
      rk_cur <= rk_next;
      rk_file[rk_count] <= rk_next;
    end
  end

  assign rk_data = rk_file[rk_index];
  // old keys are stale from the start edge on
  assign rk_avail = start ? '0 : rk_count;
  assign key_ready = !busy;

  req_held: assert property (@(posedge clk) disable iff (rst)
    lookup.req && !lookup.grant |=> lookup.req && $stable(lookup.index));

endmodule

/* logic/cipher_round.sv */
`timescale 1ns/1ps

module cipher_round (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       enc_start,
  input  aes_types_pkg::aes_block_u  text,
  sbox_lookup_if.engine              lookup,
  output aes_types_pkg::rkey_idx_t   rk_index,
  input  aes_types_pkg::aes_block_u  rk_data,
  input  aes_types_pkg::rkey_idx_t   rk_avail,
  output logic                       enc_ready,
  output aes_types_pkg::aes_block_u  dout
);
  import aes_types_pkg::*;

  logic busy;
  logic loaded;
  logic combine;
  logic start_wait;
  logic load_state;
  logic sub_we;
  logic round_done;
  rkey_idx_t round;
  logic [1:0] col;
  aes_block_u st;
  aes_block_u sub;
  aes_block_u shifted;
  aes_block_u mixed;
  aes_block_u round_out;

  function automatic col_t mix_col(col_t c);
    byte_t a0;
    byte_t a1;
    byte_t a2;
    byte_t a3;
    a0 = c[31:24];
    a1 = c[23:16];
    a2 = c[15:8];
    a3 = c[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // row r rotates left by r columns
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted.bytes[4*c + r] = st.bytes[4*((c + r) % 4) + r];
      end
    end
  end

  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixed.cols[c] = mix_col(sub.cols[c]);
    end
  end

  // last round has no mix columns
  assign round_out = (round == NUM_ROUNDS) ? sub : mixed;

  assign start_wait = (enc_start && !busy) || (busy && !loaded);
  assign load_state = start_wait && rk_avail != '0;
  assign lookup.req = loaded && !combine;
  assign lookup.index = shifted.cols[col];
  assign sub_we = lookup.req && lookup.grant;
  assign round_done = combine && rk_avail > round;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      loaded <= 1'b0;
      combine <= 1'b0;
      round <= '0;
      col <= '0;
    end
    else
    begin
      if (enc_start && !busy)
        busy <= 1'b1;
      if (load_state)
      begin
        loaded <= 1'b1;
        round <= 4'd1;
      end
      if (sub_we)
      begin
        col <= col + 2'd1;
        if (col == 2'd3)
          combine <= 1'b1;
      end
      if (round_done)
      begin
        combine <= 1'b0;
        if (round == NUM_ROUNDS)
        begin
          busy <= 1'b0;
          loaded <= 1'b0;
          round <= '0;
        end
        else
          round <= round + 4'd1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_state)
      st.cols <= text.cols ^ rk_data.cols;
    else if (round_done)
      st.cols <= round_out.cols ^ rk_data.cols;
    if (sub_we)
      sub.cols[col] <= lookup.result;
  end

  assign rk_index = round;
  assign enc_ready = !busy;
  assign dout = st;

  start_when_ready: assert property (@(posedge clk) disable iff (rst)
    enc_start |-> enc_ready);

endmodule

/* logic/aes_core.sv */
`timescale 1ns/1ps

module aes_core (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            load,
  input  logic [aes_map_pkg::ADDR_W-1:0]  address,
  input  aes_types_pkg::aes_block_u       din,
  input  logic                            key_start,
  input  logic                            enc_start,
  output logic                            key_ready,
  output logic                            enc_ready,
  output aes_types_pkg::aes_block_u       dout
);
  import aes_types_pkg::*;
  import aes_map_pkg::*;

  aes_block_u key_reg;
  aes_block_u text_reg;
  aes_block_u rk_data;
  col_t tbl_index;
  col_t tbl_data;
  rkey_idx_t rk_index;
  rkey_idx_t rk_avail;

  sbox_lookup_if key_lookup ();
  sbox_lookup_if cipher_lookup ();

  // key and text registers
  // table rows are decoded inside sbox_table
  always_ff @(posedge clk)
  begin
    if (load && address == ADDR_KEY)
      key_reg <= din;
    if (load && address == ADDR_TEXT)
      text_reg <= din;
  end

  sbox_table sbox_table_inst (
    .clk      (clk),
    .load     (load),
    .address  (address),
    .din      (din),
    .rd_index (tbl_index),
    .rd_data  (tbl_data)
  );

  sbox_arbiter sbox_arbiter_inst (
    .clk         (clk),
    .rst         (rst),
    .key_port    (key_lookup.arbiter),
    .cipher_port (cipher_lookup.arbiter),
    .rd_index    (tbl_index),
    .rd_data     (tbl_data)
  );

  key_expander key_expander_inst (
    .clk       (clk),
    .rst       (rst),
    .key_start (key_start),
    .key       (key_reg),
    .lookup    (key_lookup.engine),
    .rk_index  (rk_index),
    .rk_data   (rk_data),
    .rk_avail  (rk_avail),
    .key_ready (key_ready)
  );

  cipher_round cipher_round_inst (
    .clk       (clk),
    .rst       (rst),
    .enc_start (enc_start),
    .text      (text_reg),
    .lookup    (cipher_lookup.engine),
    .rk_index  (rk_index),
    .rk_data   (rk_data),
    .rk_avail  (rk_avail),
    .enc_ready (enc_ready),
    .dout      (dout)
  );

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held for ten rising edges
  initial
  begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

/* tb/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// table as loaded into the DUT, and the expanded keys
byte_t model_sbox [0:255];
aes_block_u model_rk [0:10];

function automatic byte_t gf_mul(byte_t a, byte_t b);
  byte_t p;
  p = 8'h00;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
      p = p ^ a;
    a = xtime(a);
  end
  return p;
endfunction

// inverse in GF(2^8) followed by the affine map
function automatic byte_t std_sbox_entry(byte_t x);
  byte_t inv;
  byte_t s;
  inv = 8'h00;
  for (int y = 1; y < 256; y++)
  begin
    if (gf_mul(x, 8'(y)) == 8'h01)
      inv = 8'(y);
  end
  s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
      ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]};
  return s ^ 8'h63;
endfunction

function automatic void model_expand(aes_block_u key);
  col_t w [0:43];
  col_t t;
  byte_t rc;
  rc = 8'h01;
  for (int i = 0; i < 4; i++)
    w[i] = key.cols[i];
  for (int i = 4; i < 44; i++)
  begin
    t = w[i-1];
    if (i % 4 == 0)
    begin
      t = {model_sbox[t[23:16]], model_sbox[t[15:8]], model_sbox[t[7:0]],
           model_sbox[t[31:24]]} ^ {rc, 24'h000000};
      rc = xtime(rc);
    end
    w[i] = w[i-4] ^ t;
  end
  for (int k = 0; k < 11; k++)
    for (int j = 0; j < 4; j++)
      model_rk[k].cols[j] = w[4*k + j];
endfunction

function automatic aes_block_u model_encrypt(aes_block_u text);
  aes_block_u s;
  aes_block_u t;
  byte_t a [0:3];
  for (int j = 0; j < 4; j++)
    s.cols[j] = text.cols[j] ^ model_rk[0].cols[j];
  for (int r = 1; r <= 10; r++)
  begin
    // sub bytes and shift rows together
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        t.bytes[4*c + row] = model_sbox[s.bytes[(4*c + 5*row) % 16]];
    if (r != 10)
    begin
      for (int c = 0; c < 4; c++)
      begin
        for (int row = 0; row < 4; row++)
          a[row] = t.bytes[4*c + row];
        for (int row = 0; row < 4; row++)
          t.bytes[4*c + row] = gf_mul(a[row], 8'h02) ^ gf_mul(a[(row + 1) % 4], 8'h03)
                               ^ a[(row + 2) % 4] ^ a[(row + 3) % 4];
      end
    end
    for (int j = 0; j < 4; j++)
      s.cols[j] = t.cols[j] ^ model_rk[r].cols[j];
  end
  return s;
endfunction

`endif

/* tb/aes_tb.sv */
`timescale 1ns/1ps

module aes_tb;
  import aes_types_pkg::*;
  import aes_map_pkg::*;

  localparam int TIMEOUT = 2000;

  logic clk;
  logic rst;
  logic load;
  logic [ADDR_W-1:0] address;
  aes_block_u din;
  logic key_start;
  logic enc_start;
  logic key_ready;
  logic enc_ready;
  aes_block_u dout;

  `include "aes_ref_model.svh"

  clk_gen clk_gen_inst (
    .clk (clk),
    .rst (rst)
  );

  aes_core aes_core_inst (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .address   (address),
    .din       (din),
    .key_start (key_start),
    .enc_start (enc_start),
    .key_ready (key_ready),
    .enc_ready (enc_ready),
    .dout      (dout)
  );

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_block(string name, aes_block_u expected, aes_block_u actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
  endtask

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    while (rst !== 1'b0)
    begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("reset was never released");
    end
  endtask

  task automatic wait_ready(bit enc);
    int cycles;
    cycles = 0;
    while (enc ? enc_ready !== 1'b1 : key_ready !== 1'b1)
    begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT)
      begin
        if (enc)
          fail_run("enc_ready never returned high after encryption start");
        else
          fail_run("key_ready never returned high after key expansion start");
      end
    end
  endtask

  task automatic host_write(logic [ADDR_W-1:0] addr, aes_block_u data);
    @(posedge clk);
    #1;
    load = 1'b1;
    address = addr;
    din = data;
    @(posedge clk);
    #1;
    load = 1'b0;
  endtask

  task automatic load_table();
    aes_block_u row_data;
    for (int row = 0; row < 16; row++)
    begin
      for (int i = 0; i < 16; i++)
        row_data.bytes[i] = model_sbox[16*row + i];
      host_write(ADDR_W'(row), row_data);
    end
  endtask

  // ready flags must drop right after the sampling edge
  task automatic start_pulse(bit do_key, bit do_enc);
    @(posedge clk);
    #1;
    key_start = do_key;
    enc_start = do_enc;
    @(posedge clk);
    #1;
    key_start = 1'b0;
    enc_start = 1'b0;
    if (do_key)
      check_flag("key_ready low after start", 1'b0, key_ready);
    if (do_enc)
      check_flag("enc_ready low after start", 1'b0, enc_ready);
  endtask

  task automatic encrypt_block(aes_block_u key, aes_block_u text, bit together);
    host_write(ADDR_KEY, key);
    host_write(ADDR_TEXT, text);
    if (together)
    begin
      start_pulse(1'b1, 1'b1);
      wait_ready(1'b0);
      wait_ready(1'b1);
    end
    else
    begin
      start_pulse(1'b1, 1'b0);
      wait_ready(1'b0);
      start_pulse(1'b0, 1'b1);
      wait_ready(1'b1);
    end
  endtask

  function automatic aes_block_u random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic void random_table();
    int j;
    byte_t tmp;
    for (int i = 0; i < 256; i++)
      model_sbox[i] = 8'(i);
    for (int i = 255; i > 0; i--)
    begin
      j = $urandom % (i + 1);
      tmp = model_sbox[i];
      model_sbox[i] = model_sbox[j];
      model_sbox[j] = tmp;
    end
  endfunction

  initial
  begin
    aes_block_u key;
    aes_block_u text;
    load = 1'b0;
    address = '0;
    din = '0;
    key_start = 1'b0;
    enc_start = 1'b0;
    void'($urandom(32'ha7f25a99));

    wait_reset_done();
    check_flag("key_ready after reset", 1'b1, key_ready);
    check_flag("enc_ready after reset", 1'b1, enc_ready);

    // FIPS-197 appendix C.1
    for (int i = 0; i < 256; i++)
      model_sbox[i] = std_sbox_entry(8'(i));
    load_table();
    encrypt_block(128'h000102030405060708090a0b0c0d0e0f,
                  128'h00112233445566778899aabbccddeeff, 1'b0);
    check_block("fips197", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, dout);

    for (int n = 0; n < 20; n++)
    begin
      random_table();
      load_table();
      key = random_block();
      text = random_block();
      encrypt_block(key, text, 1'b0);
      model_expand(key);
      check_block($sformatf("random %0d", n), model_encrypt(text), dout);
    end

    // both engines compete for the table
    for (int n = 0; n < 4; n++)
    begin
      key = random_block();
      text = random_block();
      encrypt_block(key, text, 1'b1);
      model_expand(key);
      check_block($sformatf("same cycle start %0d", n), model_encrypt(text), dout);
    end

    // new texts under the last key
    for (int n = 0; n < 6; n++)
    begin
      text = random_block();
      host_write(ADDR_TEXT, text);
      start_pulse(1'b0, 1'b1);
      wait_ready(1'b1);
      check_block($sformatf("back to back %0d", n), model_encrypt(text), dout);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+tb
logic/aes_types_pkg.sv
logic/aes_map_pkg.sv
logic/sbox_lookup_if.sv
logic/sbox_arbiter.sv
logic/sbox_table.sv
logic/key_expander.sv
logic/cipher_round.sv
logic/aes_core.sv
tb/clk_gen.sv
tb/aes_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f compile.f --top-module aes_tb -Mdir obj_dir
	./obj_dir/Vaes_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
